// ==== lsu_subsys.f ====
rtl/lsu_pkg.sv
rtl/axi_pkg.sv
rtl/lsu_agu.sv
rtl/lsu_axi_master.sv
rtl/lsu_wb.sv
rtl/axi_sram.sv
rtl/lsu_subsys.sv
verification/lsu_subsys_tb.sv

// ==== rtl/axi_pkg.sv ====
package axi_pkg;

    // Response codes.
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int STRB_W = 4;
    localparam int SIZE_W = 3;

    // Largest AxSIZE the 32-bit data bus carries in one beat.
    localparam logic [SIZE_W-1:0] SIZE_MAX = 3'd2;

endpackage

// ==== rtl/axi_sram.sv ====
module axi_sram (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           arvalid,
    output logic                           arready,
    input  logic [lsu_pkg::XLEN-1:0]       araddr,
    input  logic [axi_pkg::SIZE_W-1:0]     arsize,
    output logic                           rvalid,
    input  logic                           rready,
    output logic [lsu_pkg::XLEN-1:0]       rdata,
    output logic [1:0]                     rresp,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [lsu_pkg::XLEN-1:0]       awaddr,
    input  logic [axi_pkg::SIZE_W-1:0]     awsize,
    input  logic                           wvalid,
    output logic                           wready,
    input  logic [lsu_pkg::XLEN-1:0]       wdata,
    input  logic [axi_pkg::STRB_W-1:0]     wstrb,
    output logic                           bvalid,
    input  logic                           bready,
    output logic [1:0]                     bresp
);

    typedef enum logic [2:0] {S_INIT, S_IDLE, S_WCOL, S_RDATA, S_BRESP} state_t;

    state_t                           state;
    logic [lsu_pkg::XLEN-1:0]         mem [lsu_pkg::SRAM_WORDS];
    logic [lsu_pkg::XLEN-1:0]         awaddr_q;
    logic [axi_pkg::SIZE_W-1:0]       awsize_q;
    logic [lsu_pkg::XLEN-1:0]         wdata_q;
    logic [axi_pkg::STRB_W-1:0]       wstrb_q;
    logic                             aw_got;
    logic                             w_got;
    logic                             ar_hs;
    logic                             aw_hs;
    logic                             w_hs;
    logic                             wr_fire;
    logic [lsu_pkg::XLEN-1:0]         wr_addr;
    logic [axi_pkg::SIZE_W-1:0]       wr_size;
    logic [lsu_pkg::XLEN-1:0]         wr_data;
    logic [axi_pkg::STRB_W-1:0]       wr_strb;
    logic [1:0]                       rd_resp;
    logic [1:0]                       wr_resp;

    function automatic logic [$clog2(lsu_pkg::SRAM_WORDS)-1:0] win_idx(
        logic [lsu_pkg::XLEN-1:0] a);
        logic [lsu_pkg::XLEN-1:0] off;
        off = a - lsu_pkg::SRAM_BASE;
        return off[$clog2(lsu_pkg::SRAM_WORDS)+1:2];
    endfunction

    // Below the base the offset wraps high, so one compare covers both ends.
    function automatic logic [1:0] resp_for(logic [lsu_pkg::XLEN-1:0] a,
                                            logic [axi_pkg::SIZE_W-1:0] size);
        logic [lsu_pkg::XLEN-1:0] off;
        off = a - lsu_pkg::SRAM_BASE;
        if (off >= lsu_pkg::SRAM_WORDS * 4) begin
            return axi_pkg::RESP_DECERR;
        end
        if (size > axi_pkg::SIZE_MAX) begin
            return axi_pkg::RESP_SLVERR;
        end
        return axi_pkg::RESP_OKAY;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign arready = state == S_IDLE;
    assign awready = (state == S_IDLE && !arvalid) || (state == S_WCOL && !aw_got);
    assign wready  = (state == S_IDLE && !arvalid) || (state == S_WCOL && !w_got);
    assign rvalid  = state == S_RDATA;
    assign bvalid  = state == S_BRESP;

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    // Write fields may arrive on the same edge that completes the pair.
    assign wr_addr = aw_got ? awaddr_q : awaddr;
    assign wr_size = aw_got ? awsize_q : awsize;
    assign wr_data = w_got ? wdata_q : wdata;
    assign wr_strb = w_got ? wstrb_q : wstrb;
    assign wr_fire = (aw_got || aw_hs) && (w_got || w_hs);

    assign rd_resp = resp_for(araddr, arsize);
    assign wr_resp = resp_for(wr_addr, wr_size);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= S_INIT;
            aw_got <= 1'b0;
            w_got  <= 1'b0;
        end else begin
            case (state)
                S_INIT: state <= S_IDLE;
                S_IDLE, S_WCOL: begin
                    if (ar_hs) begin
                        state <= S_RDATA;
                    end else if (wr_fire) begin
                        state  <= S_BRESP;
                        aw_got <= 1'b0;
                        w_got  <= 1'b0;
                    end else if (aw_hs || w_hs) begin
                        state  <= S_WCOL;
                        aw_got <= aw_got || aw_hs;
                        w_got  <= w_got || w_hs;
                    end
                end
                S_RDATA: begin
                    if (rready) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    if (bready) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rresp <= rd_resp;
            rdata <= rd_resp == axi_pkg::RESP_OKAY ? mem[win_idx(araddr)] : '0;
        end
        if (aw_hs) begin
            awaddr_q <= awaddr;
            awsize_q <= awsize;
        end
        if (w_hs) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (wr_fire && (state == S_IDLE || state == S_WCOL)) begin
            bresp <= wr_resp;
            if (wr_resp == axi_pkg::RESP_OKAY) begin
                for (int i = 0; i < axi_pkg::STRB_W; i++) begin
                    if (wr_strb[i]) begin
                        mem[win_idx(wr_addr)][8*i +: 8] <= wr_data[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

// ==== rtl/lsu_agu.sv ====
module lsu_agu (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_valid,
    output logic                         req_ready,
    input  lsu_pkg::mem_op_t             req_op,
    input  logic [lsu_pkg::XLEN-1:0]     req_base,
    input  logic [lsu_pkg::XLEN-1:0]     req_offset,
    input  logic [lsu_pkg::XLEN-1:0]     req_wdata,
    input  logic [lsu_pkg::RD_W-1:0]     req_rd,
    output logic                         agu_valid,
    input  logic                         mem_ready,
    output lsu_pkg::mem_op_t             agu_op,
    output logic [lsu_pkg::XLEN-1:0]     agu_addr,
    output logic [lsu_pkg::XLEN-1:0]     agu_wdata,
    output logic [lsu_pkg::RD_W-1:0]     agu_rd,
    output logic                         agu_misaligned
);

    logic [lsu_pkg::XLEN-1:0] sum;
    logic                     misaligned;
    logic                     ready_en;

    assign sum = req_base + req_offset;

    always_comb begin
        case (lsu_pkg::op_size(req_op))
            2'd1: misaligned = sum[0];
            2'd2: misaligned = |sum[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // The entry frees up in the same cycle the memory stage takes it.
    assign req_ready = ready_en && (!agu_valid || mem_ready);

    // Ready stays low through reset and rises on the first edge after it.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            agu_valid <= 1'b0;
            ready_en  <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (req_ready) begin
                agu_valid <= req_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            agu_op         <= req_op;
            agu_addr       <= sum;
            agu_wdata      <= req_wdata;
            agu_rd         <= req_rd;
            agu_misaligned <= misaligned;
        end
    end

    // A stalled request must reach the memory stage unchanged.
    assert property (@(posedge clk) disable iff (rst)
        agu_valid && !mem_ready |=> agu_valid &&
            $stable({agu_op, agu_addr, agu_wdata, agu_rd, agu_misaligned}))
        else $error("address stage entry changed while stalled");

endmodule

// ==== rtl/lsu_axi_master.sv ====
module lsu_axi_master (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           agu_valid,
    output logic                           mem_ready,
    input  lsu_pkg::mem_op_t               agu_op,
    input  logic [lsu_pkg::XLEN-1:0]       agu_addr,
    input  logic [lsu_pkg::XLEN-1:0]       agu_wdata,
    input  logic [lsu_pkg::RD_W-1:0]       agu_rd,
    input  logic                           agu_misaligned,
    output logic                           mem_valid,
    input  logic                           wb_stage_ready,
    output logic [lsu_pkg::RD_W-1:0]       mem_rd,
    output logic                           mem_we,
    output logic [lsu_pkg::XLEN-1:0]       mem_data,
    output logic                           mem_fault,
    output logic                           arvalid,
    input  logic                           arready,
    output logic [lsu_pkg::XLEN-1:0]       araddr,
    output logic [axi_pkg::SIZE_W-1:0]     arsize,
    input  logic                           rvalid,
    output logic                           rready,
    input  logic [lsu_pkg::XLEN-1:0]       rdata,
    input  logic [1:0]                     rresp,
    output logic                           awvalid,
    input  logic                           awready,
    output logic [lsu_pkg::XLEN-1:0]       awaddr,
    output logic [axi_pkg::SIZE_W-1:0]     awsize,
    output logic                           wvalid,
    input  logic                           wready,
    output logic [lsu_pkg::XLEN-1:0]       wdata,
    output logic [axi_pkg::STRB_W-1:0]     wstrb,
    input  logic                           bvalid,
    output logic                           bready,
    input  logic [1:0]                     bresp
);

    typedef enum logic [1:0] {IDLE, ADDR, RESP, DONE} state_t;

    state_t                   state;
    lsu_pkg::mem_op_t         op_q;
    logic [1:0]               lane_q;
    logic [1:0]               size;
    logic                     is_store;
    logic                     aw_done;
    logic                     w_done;
    logic [lsu_pkg::XLEN-1:0] shifted;
    logic [lsu_pkg::XLEN-1:0] load_data;

    assign size     = lsu_pkg::op_size(op_q);
    assign is_store = lsu_pkg::op_is_store(op_q);

    assign mem_ready = state == IDLE;
    assign mem_valid = state == DONE;

    // Each write channel finishes on its own handshake.
    assign aw_done = !awvalid || awready;
    assign w_done  = !wvalid || wready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load alignment and extension.
    assign shifted = rdata >> {lane_q, 3'b000};

    always_comb begin
        case (size)
            2'd0: load_data = lsu_pkg::op_unsigned(op_q) ? {24'b0, shifted[7:0]}
                                                         : {{24{shifted[7]}}, shifted[7:0]};
            2'd1: load_data = lsu_pkg::op_unsigned(op_q) ? {16'b0, shifted[15:0]}
                                                         : {{16{shifted[15]}}, shifted[15:0]};
            default: load_data = shifted;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            arvalid   <= 1'b0;
            rready    <= 1'b0;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            bready    <= 1'b0;
            mem_we    <= 1'b0;
            mem_fault <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (agu_valid) begin
                        mem_we    <= 1'b0;
                        mem_fault <= agu_misaligned;
                        if (agu_misaligned) begin
                            // No bus activity, result goes straight out.
                            state <= DONE;
                        end else begin
                            state <= ADDR;
                            if (lsu_pkg::op_is_store(agu_op)) begin
                                awvalid <= 1'b1;
                                wvalid  <= 1'b1;
                            end else begin
                                arvalid <= 1'b1;
                            end
                        end
                    end
                end
                ADDR: begin
                    if (is_store) begin
                        if (awready) begin
                            awvalid <= 1'b0;
                        end
                        if (wready) begin
                            wvalid <= 1'b0;
                        end
                        if (aw_done && w_done) begin
                            bready <= 1'b1;
                            state  <= RESP;
                        end
                    end else if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= RESP;
                    end
                end
                RESP: begin
                    if (rvalid && rready) begin
                        rready    <= 1'b0;
                        mem_we    <= rresp == axi_pkg::RESP_OKAY;
                        mem_fault <= rresp != axi_pkg::RESP_OKAY;
                        state     <= DONE;
                    end else if (bvalid && bready) begin
                        bready    <= 1'b0;
                        mem_fault <= bresp != axi_pkg::RESP_OKAY;
                        state     <= DONE;
                    end
                end
                default: begin
                    if (wb_stage_ready) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && agu_valid) begin
            op_q     <= agu_op;
            lane_q   <= agu_addr[1:0];
            mem_rd   <= agu_rd;
            mem_data <= '0;
            araddr   <= agu_addr;
            awaddr   <= agu_addr;
            arsize   <= {1'b0, lsu_pkg::op_size(agu_op)};
            awsize   <= {1'b0, lsu_pkg::op_size(agu_op)};
            wdata    <= agu_wdata << {agu_addr[1:0], 3'b000};
            case (lsu_pkg::op_size(agu_op))
                2'd0: wstrb <= 4'b0001 << agu_addr[1:0];
                2'd1: wstrb <= 4'b0011 << agu_addr[1:0];
                default: wstrb <= 4'b1111;
            endcase
        end
        if (rvalid && rready && rresp == axi_pkg::RESP_OKAY) begin
            mem_data <= load_data;
        end
    end

    // A read never touches the write channels.
    assert property (@(posedge clk) disable iff (rst)
        state != IDLE && !is_store |-> !awvalid && !wvalid)
        else $error("write channel active during a read");

    assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped before arready");

endmodule

// ==== rtl/lsu_pkg.sv ====
package lsu_pkg;

    localparam int XLEN = 32;
    localparam int RD_W = 5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // SRAM window, 1 KiB.
    localparam logic [XLEN-1:0] SRAM_BASE = 32'h8000_0000;
    localparam int SRAM_WORDS = 256;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        OP_LB  = 4'd0,
        OP_LBU = 4'd1,
        OP_LH  = 4'd2,
        OP_LHU = 4'd3,
        OP_LW  = 4'd4,
        OP_SB  = 4'd5,
        OP_SH  = 4'd6,
        OP_SW  = 4'd7
    } mem_op_t;

    function automatic logic op_is_store(mem_op_t op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    // 0 = byte, 1 = half, 2 = word.
    function automatic logic [1:0] op_size(mem_op_t op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 2'd0;
            OP_LH, OP_LHU, OP_SH: return 2'd1;
            default: return 2'd2;
        endcase
    endfunction

    function automatic logic op_unsigned(mem_op_t op);
        return op == OP_LBU || op == OP_LHU;
    endfunction

endpackage

// ==== rtl/lsu_subsys.sv ====
module lsu_subsys (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  lsu_pkg::mem_op_t           req_op,
    input  logic [lsu_pkg::XLEN-1:0]   req_base,
    input  logic [lsu_pkg::XLEN-1:0]   req_offset,
    input  logic [lsu_pkg::XLEN-1:0]   req_wdata,
    input  logic [lsu_pkg::RD_W-1:0]   req_rd,
    output logic                       wb_valid,
    input  logic                       wb_ready,
    output logic [lsu_pkg::RD_W-1:0]   wb_rd,
    output logic                       wb_we,
    output logic [lsu_pkg::XLEN-1:0]   wb_data,
    output logic                       wb_fault
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage handoffs.
    logic                       agu_valid;
    logic                       mem_ready;
    lsu_pkg::mem_op_t           agu_op;
    logic [lsu_pkg::XLEN-1:0]   agu_addr;
    logic [lsu_pkg::XLEN-1:0]   agu_wdata;
    logic [lsu_pkg::RD_W-1:0]   agu_rd;
    logic                       agu_misaligned;
    logic                       mem_valid;
    logic                       wb_stage_ready;
    logic [lsu_pkg::RD_W-1:0]   mem_rd;
    logic                       mem_we;
    logic [lsu_pkg::XLEN-1:0]   mem_data;
    logic                       mem_fault;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI between memory stage and SRAM.
    logic                         arvalid, arready, rvalid, rready;
    logic                         awvalid, awready, wvalid, wready, bvalid, bready;
    logic [lsu_pkg::XLEN-1:0]     araddr, awaddr, rdata, wdata;
    logic [axi_pkg::SIZE_W-1:0]   arsize, awsize;
    logic [axi_pkg::STRB_W-1:0]   wstrb;
    logic [1:0]                   rresp, bresp;

    lsu_agu lsu_agu_inst (.*);

    lsu_axi_master lsu_axi_master_inst (.*);

    lsu_wb lsu_wb_inst (.*);

    axi_sram axi_sram_inst (.*);

endmodule

// ==== rtl/lsu_wb.sv ====
module lsu_wb (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       mem_valid,
    output logic                       wb_stage_ready,
    input  logic [lsu_pkg::RD_W-1:0]   mem_rd,
    input  logic                       mem_we,
    input  logic [lsu_pkg::XLEN-1:0]   mem_data,
    input  logic                       mem_fault,
    output logic                       wb_valid,
    input  logic                       wb_ready,
    output logic [lsu_pkg::RD_W-1:0]   wb_rd,
    output logic                       wb_we,
    output logic [lsu_pkg::XLEN-1:0]   wb_data,
    output logic                       wb_fault
);

    assign wb_stage_ready = !wb_valid || wb_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
            wb_fault <= 1'b0;
        end else if (wb_stage_ready) begin
            wb_valid <= mem_valid;
            if (mem_valid) begin
                wb_we    <= mem_we;
                wb_fault <= mem_fault;
            end
        end
    end

    // Index 0 when nothing is written, so the register file needs no x0 check.
    always_ff @(posedge clk) begin
        if (mem_valid && wb_stage_ready) begin
            wb_rd   <= mem_we ? mem_rd : '0;
            wb_data <= mem_data;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        wb_valid && !wb_ready |=> wb_valid && $stable({wb_rd, wb_we, wb_data, wb_fault}))
        else $error("writeback result changed while stalled");

endmodule

// ==== verification/lsu_subsys_tb.sv ====
module lsu_subsys_tb;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 10;
    localparam int REQ_TIMEOUT    = 100;
    localparam int RESULT_TIMEOUT = 200;
    localparam int DRAIN_CYCLES   = 8;
    localparam logic [31:0] WIN   = lsu_pkg::SRAM_BASE;

    typedef struct packed {
        lsu_pkg::mem_op_t          op;
        logic [31:0]               base;
        logic [31:0]               offset;
        logic [31:0]               wdata;
        logic [lsu_pkg::RD_W-1:0]  rd;
        logic [31:0]               exp_data;
        logic                      exp_we;
        logic                      exp_fault;
    } vector_t;

    logic                       clk;
    logic                       rst;
    logic                       req_valid;
    logic                       req_ready;
    lsu_pkg::mem_op_t           req_op;
    logic [lsu_pkg::XLEN-1:0]   req_base;
    logic [lsu_pkg::XLEN-1:0]   req_offset;
    logic [lsu_pkg::XLEN-1:0]   req_wdata;
    logic [lsu_pkg::RD_W-1:0]   req_rd;
    logic                       wb_valid;
    logic                       wb_ready;
    logic [lsu_pkg::RD_W-1:0]   wb_rd;
    logic                       wb_we;
    logic [lsu_pkg::XLEN-1:0]   wb_data;
    logic                       wb_fault;

    vector_t vectors[$];

    lsu_subsys lsu_subsys_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at t=%0t while %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic add_entry(input lsu_pkg::mem_op_t op, input logic [31:0] base,
                             input logic [31:0] offset, input logic [31:0] wdata,
                             input logic [4:0] rd, input logic [31:0] exp_data,
                             input logic exp_we, input logic exp_fault);
        vectors.push_back({op, base, offset, wdata, rd, exp_data, exp_we, exp_fault});
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Expected values follow from the lane, extension and fault rules.
    task automatic load_vectors();
        // Word store then load.
        add_entry(lsu_pkg::OP_SW, WIN + 32'h10, 32'h0, 32'hdeadbeef, 5'd1, 32'h0, 1'b0, 1'b0);
        add_entry(lsu_pkg::OP_LW, WIN + 32'h10, 32'h0, 32'h0, 5'd2, 32'hdeadbeef, 1'b1, 1'b0);
        // Word at 0x20 becomes c3a5_7f81.
        add_entry(lsu_pkg::OP_SB, WIN + 32'h20, 32'h0, 32'h00000081, 5'd3, 32'h0, 1'b0, 1'b0);
        add_entry(lsu_pkg::OP_SB, WIN + 32'h20, 32'h1, 32'hffffff7f, 5'd4, 32'h0, 1'b0, 1'b0);
        add_entry(lsu_pkg::OP_SH, WIN + 32'h20, 32'h2, 32'h1234c3a5, 5'd5, 32'h0, 1'b0, 1'b0);
        add_entry(lsu_pkg::OP_LW, WIN + 32'h20, 32'h0, 32'h0, 5'd6, 32'hc3a57f81, 1'b1, 1'b0);
        add_entry(lsu_pkg::OP_LB, WIN + 32'h20, 32'h0, 32'h0, 5'd7, 32'hffffff81, 1'b1, 1'b0);
        add_entry(lsu_pkg::OP_LBU, WIN + 32'h20, 32'h0, 32'h0, 5'd8, 32'h00000081, 1'b1, 1'b0);
        add_entry(lsu_pkg::OP_LB, WIN + 32'h20, 32'h1, 32'h0, 5'd9, 32'h0000007f, 1'b1, 1'b0);
        add_entry(lsu_pkg::OP_LBU, WIN + 32'h20, 32'h3, 32'h0, 5'd10, 32'h000000c3, 1'b1, 1'b0);
        add_entry(lsu_pkg::OP_LB, WIN + 32'h20, 32'h2, 32'h0, 5'd11, 32'hffffffa5, 1'b1, 1'b0);
        add_entry(lsu_pkg::OP_LH, WIN + 32'h20, 32'h2, 32'h0, 5'd12, 32'hffffc3a5, 1'b1, 1'b0);
        add_entry(lsu_pkg::OP_LHU, WIN + 32'h20, 32'h2, 32'h0, 5'd13, 32'h0000c3a5, 1'b1, 1'b0);
        add_entry(lsu_pkg::OP_LH, WIN + 32'h20, 32'h0, 32'h0, 5'd14, 32'h00007f81, 1'b1, 1'b0);
        add_entry(lsu_pkg::OP_LBU, WIN + 32'h20, 32'h2, 32'h0, 5'd3, 32'h000000a5, 1'b1, 1'b0);
        add_entry(lsu_pkg::OP_LB, WIN + 32'h20, 32'h3, 32'h0, 5'd4, 32'hffffffc3, 1'b1, 1'b0);
        // Word at 0x24 becomes 40fe_8001.
        add_entry(lsu_pkg::OP_SH, WIN + 32'h24, 32'h0, 32'h00008001, 5'd15, 32'h0, 1'b0, 1'b0);
        add_entry(lsu_pkg::OP_SB, WIN + 32'h24, 32'h2, 32'h000000fe, 5'd16, 32'h0, 1'b0, 1'b0);
        add_entry(lsu_pkg::OP_SB, WIN + 32'h24, 32'h3, 32'h00000040, 5'd17, 32'h0, 1'b0, 1'b0);
        add_entry(lsu_pkg::OP_LW, WIN + 32'h24, 32'h0, 32'h0, 5'd18, 32'h40fe8001, 1'b1, 1'b0);
        add_entry(lsu_pkg::OP_LH, WIN + 32'h24, 32'h0, 32'h0, 5'd19, 32'hffff8001, 1'b1, 1'b0);
        add_entry(lsu_pkg::OP_LHU, WIN + 32'h24, 32'h0, 32'h0, 5'd15, 32'h00008001, 1'b1, 1'b0);
        add_entry(lsu_pkg::OP_LB, WIN + 32'h24, 32'h1, 32'h0, 5'd16, 32'hffffff80, 1'b1, 1'b0);
        add_entry(lsu_pkg::OP_LBU, WIN + 32'h24, 32'h1, 32'h0, 5'd17, 32'h00000080, 1'b1, 1'b0);
        // Misaligned accesses fault and leave memory alone.
        add_entry(lsu_pkg::OP_SH, WIN + 32'h10, 32'h1, 32'h55555555, 5'd20, 32'h0, 1'b0, 1'b1);
        add_entry(lsu_pkg::OP_SW, WIN + 32'h10, 32'h2, 32'h55555555, 5'd21, 32'h0, 1'b0, 1'b1);
        add_entry(lsu_pkg::OP_LW, WIN + 32'h10, 32'h3, 32'h0, 5'd22, 32'h0, 1'b0, 1'b1);
        add_entry(lsu_pkg::OP_LH, WIN + 32'h10, 32'h1, 32'h0, 5'd23, 32'h0, 1'b0, 1'b1);
        add_entry(lsu_pkg::OP_LW, WIN + 32'h10, 32'h0, 32'h0, 5'd24, 32'hdeadbeef, 1'b1, 1'b0);
        // Outside the window on both sides.
        add_entry(lsu_pkg::OP_LW, 32'h00001000, 32'h0, 32'h0, 5'd25, 32'h0, 1'b0, 1'b1);
        add_entry(lsu_pkg::OP_SW, WIN, 32'h400, 32'h11111111, 5'd26, 32'h0, 1'b0, 1'b1);
        add_entry(lsu_pkg::OP_SB, 32'h7ffffffc, 32'h3, 32'h000000ee, 5'd27, 32'h0, 1'b0, 1'b1);
        add_entry(lsu_pkg::OP_SW, WIN + 32'h3fc, 32'h0, 32'ha5a55a5a, 5'd28, 32'h0, 1'b0, 1'b0);
        add_entry(lsu_pkg::OP_LW, WIN + 32'h3fc, 32'h0, 32'h0, 5'd29, 32'ha5a55a5a, 1'b1, 1'b0);
        // Negative offset reaches back into the last word.
        add_entry(lsu_pkg::OP_LBU, WIN + 32'h400, 32'hffffffff, 32'h0, 5'd30, 32'h000000a5,
                  1'b1, 1'b0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive_requests();
        int waited;
        for (int i = 0; i < vectors.size(); i++) begin
            req_valid  = 1'b1;
            req_op     = vectors[i].op;
            req_base   = vectors[i].base;
            req_offset = vectors[i].offset;
            req_wdata  = vectors[i].wdata;
            req_rd     = vectors[i].rd;
            waited = 0;
            while (!req_ready) begin
                @(negedge clk);
                waited++;
                if (waited > REQ_TIMEOUT) begin
                    report_timeout($sformatf("waiting for req_ready on request %0d", i));
                end
            end
            // Accepted on the coming rising edge.
            @(negedge clk);
        end
        req_valid = 1'b0;
    endtask

    task automatic collect_results();
        int                       idx;
        int                       waited;
        logic                     stalled;
        logic [lsu_pkg::RD_W-1:0] held_rd;
        logic                     held_we;
        logic [31:0]              held_data;
        logic                     held_fault;
        vector_t                  v;
        idx = 0;
        waited = 0;
        stalled = 1'b0;
        while (idx < vectors.size()) begin
            @(negedge clk);
            if (stalled) begin
                check_value($sformatf("wb_valid[%0d] stalled", idx), wb_valid, 1);
                check_value($sformatf("wb_rd[%0d] stalled", idx), wb_rd, held_rd);
                check_value($sformatf("wb_we[%0d] stalled", idx), wb_we, held_we);
                check_value($sformatf("wb_data[%0d] stalled", idx), wb_data, held_data);
                check_value($sformatf("wb_fault[%0d] stalled", idx), wb_fault, held_fault);
            end
            wb_ready   = ($urandom % 4) != 0;
            stalled    = wb_valid && !wb_ready;
            held_rd    = wb_rd;
            held_we    = wb_we;
            held_data  = wb_data;
            held_fault = wb_fault;
            if (wb_valid && wb_ready) begin
                v = vectors[idx];
                // No register index when nothing is written.
                check_value($sformatf("wb_rd[%0d]", idx), wb_rd, v.exp_we ? v.rd : 0);
                check_value($sformatf("wb_we[%0d]", idx), wb_we, v.exp_we);
                check_value($sformatf("wb_data[%0d]", idx), wb_data, v.exp_data);
                check_value($sformatf("wb_fault[%0d]", idx), wb_fault, v.exp_fault);
                idx++;
                waited = 0;
            end else begin
                waited++;
                if (waited > RESULT_TIMEOUT) begin
                    report_timeout($sformatf("waiting for result %0d", idx));
                end
            end
        end
        wb_ready = 1'b1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_op     = lsu_pkg::OP_LW;
        req_base   = '0;
        req_offset = '0;
        req_wdata  = '0;
        req_rd     = '0;
        wb_ready   = 1'b0;
        void'($urandom(32'h6d68));
        load_vectors();

        repeat (RESET_CYCLES) @(negedge clk);
        check_value("req_ready in reset", req_ready, 0);
        rst = 1'b0;
        check_value("wb_valid after reset", wb_valid, 0);

        fork
            drive_requests();
            collect_results();
        join

        // Every result was taken once and nothing more may follow.
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            @(negedge clk);
            check_value("wb_valid after last result", wb_valid, 0);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
